//--- or_decode_settings.svh
// ISA widths and fixed encodings shared by the decode stage
// include in any file that needs a width, the NOP word or the link register

`ifndef OR_DECODE_SETTINGS_SVH
`define OR_DECODE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

// instruction word and data width
`define OR_INSN_W 32

// register file address width
`define OR_REG_AW 5

//////////////////////////////////////////////////////////////////////
// fixed encodings
//////////////////////////////////////////////////////////////////////

// jump-and-link destination
`define OR_LINK_REG 5'd9

// l.nop opcode
`define OR_NOP_OPC 6'h05

// NOP inserted by flush and bubble, bit 16 marks it as void
`define OR_NOP_INSN 32'h1541_0000

`endif

//--- or_decode_pkg.sv
// opcode encodings, instruction views and control bundles of the decode stage
// modules pull these in with a wildcard import in their header
`default_nettype none

`include "or_decode_settings.svh"

package or_decode_pkg;

	// opcodes this core implements, anything else is illegal
	typedef enum logic [5:0] {
		OPC_J     = 6'h00,
		OPC_JAL   = 6'h01,
		OPC_BNF   = 6'h03,
		OPC_BF    = 6'h04,
		OPC_NOP   = `OR_NOP_OPC,
		OPC_MOVHI = 6'h06,
		OPC_XSYNC = 6'h08,
		OPC_RFE   = 6'h09,
		OPC_JR    = 6'h11,
		OPC_JALR  = 6'h12,
		OPC_LWZ   = 6'h21,
		OPC_LBZ   = 6'h23,
		OPC_LHZ   = 6'h25,
		OPC_ADDI  = 6'h27,
		OPC_ADDIC = 6'h28,
		OPC_ANDI  = 6'h29,
		OPC_ORI   = 6'h2a,
		OPC_XORI  = 6'h2b,
		OPC_SFXXI = 6'h2f,
		OPC_SW    = 6'h35,
		OPC_SB    = 6'h36,
		OPC_SH    = 6'h37,
		OPC_ALU   = 6'h38,
		OPC_SFXX  = 6'h39
	} opcode_t;

	// register form
	typedef struct packed {
		opcode_t               opcode;
		logic [`OR_REG_AW-1:0] rd;
		logic [`OR_REG_AW-1:0] ra;
		logic [`OR_REG_AW-1:0] rb;
		logic                  rsvd_10;
		logic [3:0]            op2;
		logic                  rsvd_5;
		logic [4:0]            subop;
	} insn_reg_t;

	// immediate form
	typedef struct packed {
		opcode_t               opcode;
		logic [`OR_REG_AW-1:0] rd;
		logic [`OR_REG_AW-1:0] ra;
		logic [15:0]           imm16;
	} insn_imm_t;

	typedef union packed {
		insn_reg_t r;
		insn_imm_t i;
	} insn_t;

	typedef enum logic [3:0] {
		ALU_ADD   = 4'h0,
		ALU_ADDC  = 4'h1,
		ALU_SUB   = 4'h2,
		ALU_AND   = 4'h3,
		ALU_OR    = 4'h4,
		ALU_XOR   = 4'h5,
		ALU_MOVHI = 4'hc,
		ALU_COMP  = 4'hd,
		ALU_NOP   = 4'hf
	} alu_op_t;

	typedef enum logic [2:0] {
		BR_NOP = 3'd0,
		BR_J   = 3'd1,
		BR_JR  = 3'd2,
		BR_BF  = 3'd4,
		BR_BNF = 3'd5,
		BR_RFE = 3'd6
	} branch_op_t;

	// write-back source plus write enable in bit 0
	typedef enum logic [1:0] {
		RFWB_ALU = 2'b00,
		RFWB_LR  = 2'b01,
		RFWB_LSU = 2'b10
	} rfwb_src_t;

	typedef struct packed {
		rfwb_src_t src;
		logic      we;
	} rfwb_op_t;

	typedef enum logic [3:0] {
		LSU_NOP = 4'h0,
		LSU_LBZ = 4'h4,
		LSU_LHZ = 4'h6,
		LSU_LWZ = 4'h8,
		LSU_SB  = 4'ha,
		LSU_SH  = 4'hc,
		LSU_SW  = 4'he
	} lsu_op_t;

	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_t;

	typedef struct packed {
		alu_op_t    alu_op;
		logic [3:0] alu_op2;
		logic [3:0] comp_op;
		rfwb_op_t   rfwb_op;
		branch_op_t branch_op;
		logic       illegal;
		logic       syscall;
		logic       trap;
	} ex_ctrl_t;

	typedef struct packed {
		logic id_freeze;
		logic ex_freeze;
		logic wb_freeze;
	} stall_t;

	// inactive EX control, used on reset and bubbles
	localparam ex_ctrl_t EX_CTRL_NOP = '{
		alu_op:    ALU_NOP,
		alu_op2:   4'h0,
		comp_op:   4'h0,
		rfwb_op:   '{src: RFWB_ALU, we: 1'b0},
		branch_op: BR_NOP,
		illegal:   1'b0,
		syscall:   1'b0,
		trap:      1'b0
	};

endpackage

`default_nettype wire

//--- insn_pipe_ctrl.sv
// stage registers of the decode stage with freeze, flush and bubble handling
// carries the instruction from IF through ID and EX into WB
`timescale 1ns/1ps
`default_nettype none

`include "or_decode_settings.svh"

module insn_pipe_ctrl import or_decode_pkg::*; (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire insn_t            if_insn,
	input  wire stall_t           stall,
	input  wire                   except_flush,
	input  wire                   pc_we,
	input  wire                   du_flush,
	input  wire ex_ctrl_t         id_ctrl,
	input  wire [`OR_REG_AW-1:0]  id_rf_addrw,
	input  wire                   du_hwbkpt,
	output logic                  flushpipe,
	output logic                  ex_load,
	output logic                  ex_bubble,
	output insn_t                 id_insn,
	output insn_t                 ex_insn,
	output insn_t                 wb_insn,
	output ex_ctrl_t              ex_ctrl,
	output logic [`OR_REG_AW-1:0] rf_addrw,
	output logic [`OR_REG_AW-1:0] wb_rfaddrw,
	output logic [`OR_REG_AW-1:0] rf_addra,
	output logic [`OR_REG_AW-1:0] rf_addrb,
	output logic                  rfe,
	output logic                  id_void,
	output logic                  ex_void
);

	logic     id_load;
	ex_ctrl_t ex_ctrl_nxt;

	//////////////////////////////////////////////////////////////////////
	// stage rules
	//////////////////////////////////////////////////////////////////////

	assign flushpipe = except_flush | pc_we | du_flush;
	assign id_load   = ~stall.id_freeze;
	assign ex_load   = ~stall.ex_freeze;
	// EX moves on while ID holds, so EX gets an empty slot
	assign ex_bubble = (~stall.ex_freeze & stall.id_freeze) | flushpipe;

	// register file is read while the word is still in IF
	assign rf_addra = if_insn.r.ra;
	assign rf_addrb = if_insn.r.rb;

	// inserted NOPs carry bit 16
	assign id_void = (id_insn.r.opcode == OPC_NOP) & id_insn[16];
	assign ex_void = (ex_insn.r.opcode == OPC_NOP) & ex_insn[16];

	assign rfe = (id_ctrl.branch_op == BR_RFE) | (ex_ctrl.branch_op == BR_RFE);

	// hardware breakpoint joins the trap bit on its way into EX
	always_comb begin
		ex_ctrl_nxt = id_ctrl;
		ex_ctrl_nxt.trap = id_ctrl.trap | du_hwbkpt;
	end

	//////////////////////////////////////////////////////////////////////
	// ID latch, flush wins over freeze
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_insn <= `OR_NOP_INSN;
		end else if (flushpipe) begin
			id_insn <= `OR_NOP_INSN;
		end else if (id_load) begin
			id_insn <= if_insn;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// EX registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_insn  <= `OR_NOP_INSN;
			ex_ctrl  <= EX_CTRL_NOP;
			rf_addrw <= '0;
		end else if (ex_bubble) begin
			ex_insn  <= `OR_NOP_INSN;
			ex_ctrl  <= EX_CTRL_NOP;
			rf_addrw <= '0;
		end else if (ex_load) begin
			ex_insn  <= id_insn;
			ex_ctrl  <= ex_ctrl_nxt;
			rf_addrw <= id_rf_addrw;
		end
	end

	// WB keeps its word through a flush
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_insn    <= `OR_NOP_INSN;
			wb_rfaddrw <= '0;
		end else if (!stall.wb_freeze) begin
			wb_insn    <= ex_insn;
			wb_rfaddrw <= rf_addrw;
		end
	end

endmodule

`default_nettype wire

//--- id_decoder.sv
// combinational decode of the ID instruction into the EX control bundle
// also gives the write address, branch and load/store ops and sel_imm
`timescale 1ns/1ps
`default_nettype none

`include "or_decode_settings.svh"

module id_decoder import or_decode_pkg::*; (
	input  wire insn_t            id_insn,
	output ex_ctrl_t              id_ctrl,
	output logic [`OR_REG_AW-1:0] id_rf_addrw,
	output branch_op_t            id_branch_op,
	output lsu_op_t               id_lsu_op,
	output logic                  sel_imm
);

	// ALU sub-ops of the absent multiplier and divider
	localparam logic [4:0] SUBOP_MUL  = 5'h06;
	localparam logic [4:0] SUBOP_DIV  = 5'h09;
	localparam logic [4:0] SUBOP_DIVU = 5'h0a;
	localparam logic [4:0] SUBOP_MULU = 5'h0b;

	opcode_t  opc;
	alu_op_t  alu_op;
	rfwb_op_t rfwb_op;
	logic     alu_muldiv;
	logic     illegal;
	logic     syscall;
	logic     trap;

	assign opc = id_insn.i.opcode;

	assign alu_muldiv = (id_insn.r.subop == SUBOP_MUL) | (id_insn.r.subop == SUBOP_MULU) |
		(id_insn.r.subop == SUBOP_DIV) | (id_insn.r.subop == SUBOP_DIVU);

	// l.sys and l.trap share XSYNC, told apart by [25:23]
	assign syscall = (opc == OPC_XSYNC) & (id_insn.i.rd[4:2] == 3'b000);
	assign trap    = (opc == OPC_XSYNC) & (id_insn.i.rd[4:2] == 3'b010);

	//////////////////////////////////////////////////////////////////////
	// ALU and write-back
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (opc)
			OPC_MOVHI:          alu_op = ALU_MOVHI;
			OPC_ADDI:           alu_op = ALU_ADD;
			OPC_ADDIC:          alu_op = ALU_ADDC;
			OPC_ANDI:           alu_op = ALU_AND;
			OPC_ORI:            alu_op = ALU_OR;
			OPC_XORI:           alu_op = ALU_XOR;
			OPC_SFXXI, OPC_SFXX: alu_op = ALU_COMP;
			// register form passes the sub-op straight through
			OPC_ALU:            alu_op = alu_op_t'(id_insn.r.subop[3:0]);
			default:            alu_op = ALU_NOP;
		endcase
	end

	always_comb begin
		case (opc)
			OPC_JAL, OPC_JALR:
				rfwb_op = '{src: RFWB_LR, we: 1'b1};
			OPC_MOVHI, OPC_ADDI, OPC_ADDIC, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_ALU:
				rfwb_op = '{src: RFWB_ALU, we: 1'b1};
			OPC_LWZ, OPC_LBZ, OPC_LHZ:
				rfwb_op = '{src: RFWB_LSU, we: 1'b1};
			default:
				rfwb_op = '{src: RFWB_ALU, we: 1'b0};
		endcase
	end

	// link goes to r9, everything else to rd
	assign id_rf_addrw = ((opc == OPC_JAL) | (opc == OPC_JALR)) ? `OR_LINK_REG : id_insn.i.rd;

	//////////////////////////////////////////////////////////////////////
	// branch, load/store, immediate use and legality
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (opc)
			OPC_J, OPC_JAL:   id_branch_op = BR_J;
			OPC_JR, OPC_JALR: id_branch_op = BR_JR;
			OPC_BNF:          id_branch_op = BR_BNF;
			OPC_BF:           id_branch_op = BR_BF;
			OPC_RFE:          id_branch_op = BR_RFE;
			default:          id_branch_op = BR_NOP;
		endcase
	end

	always_comb begin
		case (opc)
			OPC_LWZ: id_lsu_op = LSU_LWZ;
			OPC_LBZ: id_lsu_op = LSU_LBZ;
			OPC_LHZ: id_lsu_op = LSU_LHZ;
			OPC_SW:  id_lsu_op = LSU_SW;
			OPC_SB:  id_lsu_op = LSU_SB;
			OPC_SH:  id_lsu_op = LSU_SH;
			default: id_lsu_op = LSU_NOP;
		endcase
	end

	// stores take rb as data, so no immediate on operand B
	always_comb begin
		case (opc)
			OPC_JALR, OPC_JR, OPC_RFE, OPC_XSYNC, OPC_SW, OPC_SB, OPC_SH,
			OPC_ALU, OPC_SFXX, OPC_NOP:
				sel_imm = 1'b0;
			default:
				sel_imm = 1'b1;
		endcase
	end

	always_comb begin
		case (opc)
			OPC_J, OPC_JAL, OPC_BNF, OPC_BF, OPC_NOP, OPC_MOVHI, OPC_XSYNC, OPC_RFE,
			OPC_JR, OPC_JALR, OPC_LWZ, OPC_LBZ, OPC_LHZ, OPC_ADDI, OPC_ADDIC,
			OPC_ANDI, OPC_ORI, OPC_XORI, OPC_SFXXI, OPC_SW, OPC_SB, OPC_SH, OPC_SFXX:
				illegal = 1'b0;
			OPC_ALU:
				illegal = alu_muldiv;
			default:
				illegal = 1'b1;
		endcase
	end

	assign id_ctrl = '{
		alu_op:    alu_op,
		alu_op2:   id_insn.r.op2,
		comp_op:   id_insn.r.rd[3:0],
		rfwb_op:   rfwb_op,
		branch_op: id_branch_op,
		illegal:   illegal,
		syscall:   syscall,
		trap:      trap
	};

endmodule

`default_nettype wire

//--- imm_extend.sv
// immediate extension in ID and the branch target, both carried into EX
// the EX copies follow the same load and bubble rules as the EX control
`timescale 1ns/1ps
`default_nettype none

`include "or_decode_settings.svh"

module imm_extend import or_decode_pkg::*; (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire insn_t             id_insn,
	input  wire [`OR_INSN_W-1:0]   id_pc,
	input  wire                    ex_load,
	input  wire                    ex_bubble,
	output logic [`OR_INSN_W-1:0]  id_simm,
	output logic [`OR_INSN_W-1:0]  ex_simm,
	output logic [`OR_INSN_W-3:0]  ex_branch_target
);

	logic [`OR_INSN_W-3:0] id_branch_target;

	always_comb begin
		case (id_insn.i.opcode)
			OPC_ADDI, OPC_ADDIC, OPC_LWZ, OPC_LBZ, OPC_LHZ, OPC_XORI, OPC_SFXXI:
				id_simm = {{16{id_insn.i.imm16[15]}}, id_insn.i.imm16};
			// store offset is split around rb
			OPC_SW, OPC_SB, OPC_SH:
				id_simm = {{16{id_insn.r.rd[4]}}, id_insn.r.rd, id_insn[10:0]};
			default:
				id_simm = {16'h0000, id_insn.i.imm16};
		endcase
	end

	// word target, 26-bit offset sign-extended
	assign id_branch_target = {{4{id_insn[25]}}, id_insn[25:0]} + id_pc[`OR_INSN_W-1:2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_simm          <= '0;
			ex_branch_target <= '0;
		end else if (ex_bubble) begin
			ex_simm          <= '0;
			ex_branch_target <= '0;
		end else if (ex_load) begin
			ex_simm          <= id_simm;
			ex_branch_target <= id_branch_target;
		end
	end

endmodule

`default_nettype wire

//--- operand_select.sv
// picks the source of operands A and B for the ID instruction
// EX forwarding beats WB forwarding, which beats the register file
`timescale 1ns/1ps
`default_nettype none

`include "or_decode_settings.svh"

module operand_select import or_decode_pkg::*; (
	input  wire insn_t            id_insn,
	input  wire                   sel_imm,
	input  wire [`OR_REG_AW-1:0]  rf_addrw,
	input  wire                   ex_wr,
	input  wire [`OR_REG_AW-1:0]  wb_rfaddrw,
	input  wire                   wbforw_valid,
	output sel_t                  sel_a,
	output sel_t                  sel_b
);

	// source for one register read, same rule for A and B
	function automatic sel_t fwd_src(
		input logic [`OR_REG_AW-1:0] addr,
		input logic [`OR_REG_AW-1:0] ex_addr,
		input logic                  ex_we,
		input logic [`OR_REG_AW-1:0] wb_addr,
		input logic                  wb_valid
	);
		sel_t src;
		if ((addr == ex_addr) && ex_we) begin
			src = SEL_EX_FORW;
		end else if ((addr == wb_addr) && wb_valid) begin
			src = SEL_WB_FORW;
		end else begin
			src = SEL_RF;
		end
		return src;
	endfunction

	assign sel_a = fwd_src(id_insn.r.ra, rf_addrw, ex_wr, wb_rfaddrw, wbforw_valid);

	// immediate replaces rb outright
	assign sel_b = sel_imm ? SEL_IMM :
		fwd_src(id_insn.r.rb, rf_addrw, ex_wr, wb_rfaddrw, wbforw_valid);

endmodule

`default_nettype wire

//--- or_decode_top.sv
// decode stage top, connects pipe control, decoder, immediates and forwarding
// the surrounding core drives the stalls and flushes and reads the EX bundle
`timescale 1ns/1ps
`default_nettype none

`include "or_decode_settings.svh"

module or_decode_top import or_decode_pkg::*; (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire insn_t                  if_insn,
	input  wire stall_t                 stall,
	input  wire                         except_flush,
	input  wire                         pc_we,
	input  wire                         du_flush,
	input  wire [`OR_INSN_W-1:0]        id_pc,
	input  wire                         wbforw_valid,
	input  wire                         du_hwbkpt,
	output logic                        flushpipe,
	output insn_t                       id_insn,
	output insn_t                       ex_insn,
	output insn_t                       wb_insn,
	output ex_ctrl_t                    ex_ctrl,
	output logic [`OR_REG_AW-1:0]       rf_addrw,
	output logic [`OR_REG_AW-1:0]       rf_addra,
	output logic [`OR_REG_AW-1:0]       rf_addrb,
	output logic [`OR_INSN_W-1:0]       id_simm,
	output logic [`OR_INSN_W-1:0]       ex_simm,
	output logic [`OR_INSN_W-3:0]       ex_branch_target,
	output branch_op_t                  id_branch_op,
	output lsu_op_t                     id_lsu_op,
	output sel_t                        sel_a,
	output sel_t                        sel_b,
	output logic                        rfe,
	output logic                        id_void,
	output logic                        ex_void
);

	ex_ctrl_t              id_ctrl;
	logic [`OR_REG_AW-1:0] id_rf_addrw;
	logic [`OR_REG_AW-1:0] wb_rfaddrw;
	logic                  sel_imm;
	logic                  ex_load;
	logic                  ex_bubble;

	insn_pipe_ctrl i_pipe (
		.clk, .rst_n, .if_insn, .stall, .except_flush, .pc_we, .du_flush,
		.id_ctrl, .id_rf_addrw, .du_hwbkpt, .flushpipe, .ex_load, .ex_bubble,
		.id_insn, .ex_insn, .wb_insn, .ex_ctrl, .rf_addrw, .wb_rfaddrw,
		.rf_addra, .rf_addrb, .rfe, .id_void, .ex_void
	);

	id_decoder i_dec (
		.id_insn, .id_ctrl, .id_rf_addrw, .id_branch_op, .id_lsu_op, .sel_imm
	);

	imm_extend i_imm (
		.clk, .rst_n, .id_insn, .id_pc, .ex_load, .ex_bubble,
		.id_simm, .ex_simm, .ex_branch_target
	);

	// EX write enable gates forwarding from EX
	operand_select i_opsel (
		.id_insn, .sel_imm, .rf_addrw, .ex_wr(ex_ctrl.rfwb_op.we),
		.wb_rfaddrw, .wbforw_valid, .sel_a, .sel_b
	);

endmodule

`default_nettype wire

//--- or_decode_chk.sv
// concurrent checks on the stage registers, bound into every insn_pipe_ctrl
// covers the flush NOP, the EX bubble and the EX to WB hand-over
`timescale 1ns/1ps
`default_nettype none

`include "or_decode_settings.svh"

module or_decode_chk import or_decode_pkg::*; (
	input wire           clk,
	input wire           rst_n,
	input wire stall_t   stall,
	input wire           flushpipe,
	input wire           ex_bubble,
	input wire insn_t    id_insn,
	input wire insn_t    ex_insn,
	input wire insn_t    wb_insn,
	input wire ex_ctrl_t ex_ctrl
);

	flush_gives_nop: assert property (@(posedge clk) disable iff (!rst_n)
		flushpipe |=> (id_insn == `OR_NOP_INSN))
	else $error("id_insn is not the NOP after a flush");

	bubble_clears_ex: assert property (@(posedge clk) disable iff (!rst_n)
		ex_bubble |=> (ex_ctrl == EX_CTRL_NOP))
	else $error("ex_ctrl is not the NOP control after a bubble");

	// WB copies EX unless it is frozen
	wb_follows_ex: assert property (@(posedge clk) disable iff (!rst_n)
		!stall.wb_freeze |=> (wb_insn == $past(ex_insn)))
	else $error("wb_insn did not take ex_insn");

endmodule

bind insn_pipe_ctrl or_decode_chk i_chk (
	.clk(clk), .rst_n(rst_n), .stall(stall), .flushpipe(flushpipe), .ex_bubble(ex_bubble),
	.id_insn(id_insn), .ex_insn(ex_insn), .wb_insn(wb_insn), .ex_ctrl(ex_ctrl)
);

`default_nettype wire

//--- tb_or_decode.sv
// testbench for the decode stage top, drives a decode table and directed sequences
// run through run.sh, which builds it with Verilator from tb.f
`timescale 1ns/1ps
`default_nettype none

`include "or_decode_settings.svh"

module tb_or_decode import or_decode_pkg::*; ();

	localparam int N_ROWS = 23;
	localparam logic [1:0] EXT_ZERO = 2'd0;
	localparam logic [1:0] EXT_SIGN = 2'd1;
	localparam logic [1:0] EXT_STORE = 2'd2;
	localparam rfwb_op_t WB_NONE = '{src: RFWB_ALU, we: 1'b0};
	localparam rfwb_op_t WB_ALU = '{src: RFWB_ALU, we: 1'b1};
	localparam rfwb_op_t WB_LSU = '{src: RFWB_LSU, we: 1'b1};
	localparam rfwb_op_t WB_LR = '{src: RFWB_LR, we: 1'b1};

	// one instruction and what EX must show for it
	typedef struct packed {
		logic [31:0] insn;
		logic [3:0]  alu_op;
		rfwb_op_t    rfwb_op;
		logic [4:0]  addrw;
		logic        illegal;
		logic        syscall;
		logic        trap;
		logic        hwbkpt;
		logic [31:0] simm;
	} row_t;

	logic                  clk;
	logic                  rst_n;
	insn_t                 if_insn;
	stall_t                stall;
	logic                  except_flush;
	logic                  pc_we;
	logic                  du_flush;
	logic [`OR_INSN_W-1:0] id_pc;
	logic                  wbforw_valid;
	logic                  du_hwbkpt;
	logic                  flushpipe;
	insn_t                 id_insn;
	insn_t                 ex_insn;
	insn_t                 wb_insn;
	ex_ctrl_t              ex_ctrl;
	logic [`OR_REG_AW-1:0] rf_addrw;
	logic [`OR_REG_AW-1:0] rf_addra;
	logic [`OR_REG_AW-1:0] rf_addrb;
	logic [`OR_INSN_W-1:0] id_simm;
	logic [`OR_INSN_W-1:0] ex_simm;
	logic [`OR_INSN_W-3:0] ex_branch_target;
	branch_op_t            id_branch_op;
	lsu_op_t               id_lsu_op;
	sel_t                  sel_a;
	sel_t                  sel_b;
	logic                  rfe;
	logic                  id_void;
	logic                  ex_void;

	row_t     rows [N_ROWS];
	int       n_rows;
	int       errors;
	integer   seed;
	ex_ctrl_t held_ctrl;
	insn_t    held_insn;

	or_decode_top i_dut (
		.clk(clk), .rst_n(rst_n), .if_insn(if_insn), .stall(stall),
		.except_flush(except_flush), .pc_we(pc_we), .du_flush(du_flush), .id_pc(id_pc),
		.wbforw_valid(wbforw_valid), .du_hwbkpt(du_hwbkpt), .flushpipe(flushpipe),
		.id_insn(id_insn), .ex_insn(ex_insn), .wb_insn(wb_insn), .ex_ctrl(ex_ctrl),
		.rf_addrw(rf_addrw), .rf_addra(rf_addra), .rf_addrb(rf_addrb), .id_simm(id_simm),
		.ex_simm(ex_simm), .ex_branch_target(ex_branch_target), .id_branch_op(id_branch_op),
		.id_lsu_op(id_lsu_op), .sel_a(sel_a), .sel_b(sel_b), .rfe(rfe), .id_void(id_void),
		.ex_void(ex_void)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ends a run that hangs, sized from the table length
	initial begin
		repeat ((N_ROWS + 20) * 4) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("Done: errors found");
		$fatal(1, "timeout");
	end

	//////////////////////////////////////////////////////////////////////
	// table and checks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [4:0] rand5();
		logic [31:0] r;
		r = $random(seed);
		return r[4:0];
	endfunction

	// flags are {illegal, syscall, trap, hwbkpt}
	task automatic add_row(input logic [5:0] opc, input logic [4:0] rd, input logic [15:0] low,
		input logic [3:0] alu, input rfwb_op_t wb, input logic link, input logic [3:0] flags,
		input logic [1:0] ext);
		row_t r;
		r.insn = {opc, rd, rand5(), low};
		r.alu_op = alu;
		r.rfwb_op = wb;
		r.addrw = link ? 5'd9 : rd;
		{r.illegal, r.syscall, r.trap, r.hwbkpt} = flags;
		case (ext)
			EXT_SIGN:  r.simm = {{16{low[15]}}, low};
			EXT_STORE: r.simm = {{16{rd[4]}}, rd, low[10:0]};
			default:   r.simm = {16'h0000, low};
		endcase
		rows[n_rows] = r;
		n_rows++;
	endtask

	task automatic build_table();
		add_row(OPC_ADDI, rand5(), 16'h8004, 4'h0, WB_ALU, 1'b0, 4'b0000, EXT_SIGN);
		add_row(OPC_ADDIC, rand5(), 16'h0123, 4'h1, WB_ALU, 1'b0, 4'b0000, EXT_SIGN);
		add_row(OPC_ANDI, rand5(), 16'hf00f, 4'h3, WB_ALU, 1'b0, 4'b0000, EXT_ZERO);
		add_row(OPC_ORI, rand5(), 16'h8000, 4'h4, WB_ALU, 1'b0, 4'b0000, EXT_ZERO);
		add_row(OPC_XORI, rand5(), 16'hfffe, 4'h5, WB_ALU, 1'b0, 4'b0000, EXT_SIGN);
		add_row(OPC_MOVHI, rand5(), 16'h1234, 4'hc, WB_ALU, 1'b0, 4'b0000, EXT_ZERO);
		// register form, low half is {rb, op2, sub-op}
		add_row(OPC_ALU, rand5(), {rand5(), 6'h00, 5'h00}, 4'h0, WB_ALU, 1'b0, 4'b0000, EXT_ZERO);
		add_row(OPC_ALU, rand5(), {rand5(), 6'h00, 5'h02}, 4'h2, WB_ALU, 1'b0, 4'b0000, EXT_ZERO);
		add_row(OPC_ALU, rand5(), {rand5(), 6'h00, 5'h03}, 4'h3, WB_ALU, 1'b0, 4'b0000, EXT_ZERO);
		// mul and divu have no unit behind them
		add_row(OPC_ALU, rand5(), {rand5(), 6'h00, 5'h06}, 4'h6, WB_ALU, 1'b0, 4'b1000, EXT_ZERO);
		add_row(OPC_ALU, rand5(), {rand5(), 6'h00, 5'h0a}, 4'ha, WB_ALU, 1'b0, 4'b1000, EXT_ZERO);
		add_row(OPC_LWZ, rand5(), 16'hfff0, 4'hf, WB_LSU, 1'b0, 4'b0000, EXT_SIGN);
		add_row(OPC_LBZ, rand5(), 16'h0010, 4'hf, WB_LSU, 1'b0, 4'b0000, EXT_SIGN);
		add_row(OPC_LHZ, rand5(), 16'h8002, 4'hf, WB_LSU, 1'b0, 4'b0000, EXT_SIGN);
		add_row(OPC_SW, rand5(), {rand5(), 11'h400}, 4'hf, WB_NONE, 1'b0, 4'b0000, EXT_STORE);
		add_row(OPC_SB, rand5(), {rand5(), 11'h00c}, 4'hf, WB_NONE, 1'b0, 4'b0000, EXT_STORE);
		add_row(OPC_JAL, rand5(), 16'h0040, 4'hf, WB_LR, 1'b1, 4'b0000, EXT_ZERO);
		add_row(OPC_XSYNC, 5'b00001, 16'h0000, 4'hf, WB_NONE, 1'b0, 4'b0100, EXT_ZERO);
		add_row(OPC_XSYNC, 5'b01000, 16'h0000, 4'hf, WB_NONE, 1'b0, 4'b0010, EXT_ZERO);
		add_row(6'h3f, rand5(), 16'h0000, 4'hf, WB_NONE, 1'b0, 4'b1000, EXT_ZERO);
		// mfspr is gone from this core
		add_row(6'h2d, rand5(), 16'h0000, 4'hf, WB_NONE, 1'b0, 4'b1000, EXT_ZERO);
		add_row(OPC_SFXXI, rand5(), 16'h8001, 4'hd, WB_NONE, 1'b0, 4'b0000, EXT_SIGN);
		add_row(OPC_ADDI, rand5(), 16'h0007, 4'h0, WB_ALU, 1'b0, 4'b0011, EXT_SIGN);
	endtask

	// branch op an opcode has to produce
	function automatic branch_op_t branch_for_opc(input logic [5:0] opc);
		branch_op_t b;
		case (opc)
			OPC_J, OPC_JAL:   b = BR_J;
			OPC_JR, OPC_JALR: b = BR_JR;
			OPC_BNF:          b = BR_BNF;
			OPC_BF:           b = BR_BF;
			OPC_RFE:          b = BR_RFE;
			default:          b = BR_NOP;
		endcase
		return b;
	endfunction

	// load/store op an opcode has to produce
	function automatic lsu_op_t lsu_for_opc(input logic [5:0] opc);
		lsu_op_t l;
		case (opc)
			OPC_LWZ: l = LSU_LWZ;
			OPC_LBZ: l = LSU_LBZ;
			OPC_LHZ: l = LSU_LHZ;
			OPC_SW:  l = LSU_SW;
			OPC_SB:  l = LSU_SB;
			OPC_SH:  l = LSU_SH;
			default: l = LSU_NOP;
		endcase
		return l;
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("MISMATCH at %0t ns: %s", $time, msg);
		$display("Done: errors found");
		$fatal(1, "stopping at the first mismatch");
	endtask

	function automatic logic ctrl_inactive(input ex_ctrl_t c);
		return (c.alu_op == ALU_NOP) && !c.rfwb_op.we && (c.branch_op == BR_NOP) &&
			!c.illegal && !c.syscall && !c.trap;
	endfunction

	task automatic check_id(input row_t r, input int idx);
		assert (id_simm == r.simm)
		else report_mismatch($sformatf("row %0d id_simm %h, expected %h", idx, id_simm, r.simm));
		assert ((id_branch_op == branch_for_opc(r.insn[31:26])) &&
			(id_lsu_op == lsu_for_opc(r.insn[31:26])))
		else report_mismatch($sformatf("row %0d branch/lsu op %0d/%0d, expected %0d/%0d", idx,
			id_branch_op, id_lsu_op, branch_for_opc(r.insn[31:26]),
			lsu_for_opc(r.insn[31:26])));
	endtask

	task automatic check_ex(input row_t r, input int idx);
		logic [`OR_INSN_W-3:0] target;
		// word target, sign-extended 26-bit offset plus the ID word address
		target = {{4{r.insn[25]}}, r.insn[25:0]} + id_pc[`OR_INSN_W-1:2];
		assert ((ex_ctrl.alu_op == r.alu_op) && (ex_ctrl.rfwb_op == r.rfwb_op))
		else report_mismatch($sformatf("row %0d alu/wb op %h/%h, expected %h/%h", idx,
			ex_ctrl.alu_op, ex_ctrl.rfwb_op, r.alu_op, r.rfwb_op));
		assert (rf_addrw == r.addrw)
		else report_mismatch($sformatf("row %0d rf_addrw %0d, expected %0d", idx, rf_addrw,
			r.addrw));
		assert ({ex_ctrl.illegal, ex_ctrl.syscall, ex_ctrl.trap} ==
			{r.illegal, r.syscall, r.trap})
		else report_mismatch($sformatf("row %0d illegal/syscall/trap %b%b%b, expected %b%b%b",
			idx, ex_ctrl.illegal, ex_ctrl.syscall, ex_ctrl.trap, r.illegal, r.syscall, r.trap));
		assert (ex_simm == r.simm)
		else report_mismatch($sformatf("row %0d ex_simm %h, expected %h", idx, ex_simm, r.simm));
		assert ((ex_insn == r.insn) && !ex_void)
		else report_mismatch($sformatf("row %0d ex_insn %h, expected %h", idx, ex_insn,
			r.insn));
		assert ((ex_ctrl.branch_op == branch_for_opc(r.insn[31:26])) &&
			(ex_ctrl.alu_op2 == r.insn[9:6]) && (ex_ctrl.comp_op == r.insn[24:21]))
		else report_mismatch($sformatf("row %0d branch/op2/comp %0d/%h/%h, expected %0d/%h/%h",
			idx, ex_ctrl.branch_op, ex_ctrl.alu_op2, ex_ctrl.comp_op,
			branch_for_opc(r.insn[31:26]), r.insn[9:6], r.insn[24:21]));
		assert (ex_branch_target == target)
		else report_mismatch($sformatf("row %0d ex_branch_target %h, expected %h", idx,
			ex_branch_target, target));
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed = 32'hef1b_24e1;
		errors = 0;
		n_rows = 0;
		rst_n = 1'b0;
		if_insn = `OR_NOP_INSN;
		stall = '0;
		except_flush = 1'b0;
		pc_we = 1'b0;
		du_flush = 1'b0;
		id_pc = 32'h0000_1000;
		wbforw_valid = 1'b0;
		du_hwbkpt = 1'b0;
		build_table();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// row k-1 sits in ID, row k-2 in EX and row k-3 in WB at each falling edge
		for (int k = 0; k < N_ROWS + 3; k++) begin
			@(negedge clk);
			if (k >= 1 && k <= N_ROWS)
				check_id(rows[k-1], k - 1);
			if (k >= 2 && k <= N_ROWS + 1)
				check_ex(rows[k-2], k - 2);
			if (k >= 3) begin
				assert (wb_insn == rows[k-3].insn)
				else report_mismatch($sformatf("row %0d wb_insn %h, expected %h", k - 3,
					wb_insn, rows[k-3].insn));
			end
			if_insn = (k < N_ROWS) ? rows[k].insn : `OR_NOP_INSN;
			du_hwbkpt = (k >= 1 && k <= N_ROWS) ? rows[k-1].hwbkpt : 1'b0;
		end

		// forwarding from EX, then from WB
		@(negedge clk);
		if_insn = {OPC_ADDI, 5'd5, 5'd1, 16'h0010};
		@(negedge clk);
		if_insn = {OPC_ALU, 5'd6, 5'd5, 5'd2, 11'h000};
		@(negedge clk);
		assert (sel_a == SEL_EX_FORW)
		else report_mismatch($sformatf("sel_a %0d, expected EX forwarding", sel_a));
		assert (sel_b == SEL_RF)
		else report_mismatch($sformatf("sel_b %0d, expected register file", sel_b));
		if_insn = {OPC_ORI, 5'd7, 5'd5, 16'h00ff};
		wbforw_valid = 1'b1;
		@(negedge clk);
		assert (sel_a == SEL_WB_FORW)
		else report_mismatch($sformatf("sel_a %0d, expected WB forwarding", sel_a));
		assert (sel_b == SEL_IMM)
		else report_mismatch($sformatf("sel_b %0d, expected immediate", sel_b));
		wbforw_valid = 1'b0;

		// flush while an ADDI sits in ID
		if_insn = {OPC_ADDI, 5'd3, 5'd4, 16'h0001};
		@(negedge clk);
		pc_we = 1'b1;
		if_insn = {OPC_ORI, 5'd8, 5'd8, 16'h0002};
		@(negedge clk);
		assert (flushpipe)
		else report_mismatch("flushpipe low while pc_we is high");
		pc_we = 1'b0;
		assert ((id_insn == `OR_NOP_INSN) && id_void)
		else report_mismatch($sformatf("id_insn %h after flush, expected the NOP", id_insn));
		assert (ctrl_inactive(ex_ctrl))
		else report_mismatch("EX control active on the flush edge");
		@(negedge clk);
		assert (ctrl_inactive(ex_ctrl) && ex_void)
		else report_mismatch("EX control active one edge after the flush");

		// the other two flush sources
		except_flush = 1'b1;
		@(negedge clk);
		assert (flushpipe && id_void)
		else report_mismatch("flushpipe or id_void low after except_flush");
		except_flush = 1'b0;
		du_flush = 1'b1;
		@(negedge clk);
		assert (flushpipe && id_void)
		else report_mismatch("flushpipe or id_void low after du_flush");
		du_flush = 1'b0;

		// ID freeze gives a bubble, full freeze holds, release completes row 0
		if_insn = rows[0].insn;
		@(negedge clk);
		stall = '{id_freeze: 1'b1, ex_freeze: 1'b0, wb_freeze: 1'b0};
		if_insn = rows[1].insn;
		@(negedge clk);
		assert ((id_insn == rows[0].insn) && ctrl_inactive(ex_ctrl) && ex_void)
		else report_mismatch("ID freeze did not hold ID and bubble EX");
		// register file addresses come from the IF word, not the held ID word
		assert ((rf_addra == rows[1].insn[20:16]) && (rf_addrb == rows[1].insn[15:11]))
		else report_mismatch($sformatf("rf_addra/rf_addrb %0d/%0d, expected %0d/%0d",
			rf_addra, rf_addrb, rows[1].insn[20:16], rows[1].insn[15:11]));
		stall = '{id_freeze: 1'b1, ex_freeze: 1'b1, wb_freeze: 1'b1};
		held_ctrl = ex_ctrl;
		held_insn = id_insn;
		repeat (3) @(negedge clk);
		assert ((id_insn == held_insn) && (ex_ctrl == held_ctrl))
		else report_mismatch("full freeze changed id_insn or ex_ctrl");
		stall = '0;
		@(negedge clk);
		check_ex(rows[0], 0);
		assert (id_insn == rows[1].insn)
		else report_mismatch($sformatf("id_insn %h after release, expected %h", id_insn,
			rows[1].insn));

		// rfe is seen from ID and then from EX
		if_insn = {OPC_RFE, 26'h0};
		@(negedge clk);
		assert (rfe && (id_branch_op == BR_RFE))
		else report_mismatch("rfe or id_branch_op wrong with l.rfe in ID");
		if_insn = `OR_NOP_INSN;
		@(negedge clk);
		assert (rfe && (ex_ctrl.branch_op == BR_RFE))
		else report_mismatch("rfe or EX branch_op wrong with l.rfe in EX");
		@(negedge clk);
		assert (!rfe)
		else report_mismatch("rfe high with no l.rfe in ID or EX");

		if (errors == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_or_decode -f tb.f

sim_out=$(./obj_dir/Vtb_or_decode 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'Done: no errors'; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- tb.f
+incdir+.
or_decode_pkg.sv
insn_pipe_ctrl.sv
id_decoder.sv
imm_extend.sv
operand_select.sv
or_decode_top.sv
or_decode_chk.sv
tb_or_decode.sv
